/* dv/tb_biquad_cascade.sv */
`timescale 1ns/10ps

module tb_biquad_cascade;

    // Sample counts per test, they size the watchdog
    localparam int  N_UNITY = 40;
    localparam int  N_RAND = 200;
    localparam int  N_SAT = 60;
    localparam int  N_BYP = 180;
    localparam int  N_CHG = 120;
    localparam int  N_TOTAL = N_UNITY + N_RAND + N_SAT + N_BYP + N_CHG;
    localparam longint TIMEOUT_NS = longint'(N_TOTAL * 4 + 200) * 100;

    // Register indices within a section's block of eight
    localparam int  IDX_B0 = 0;
    localparam int  IDX_B1 = 1;
    localparam int  IDX_B2 = 2;
    localparam int  IDX_A1 = 3;
    localparam int  IDX_A2 = 4;
    localparam int  IDX_BYPASS = 5;

    // 24-bit signed clamp limits
    localparam longint Y_MAX = 8388607;
    localparam longint Y_MIN = -8388608;

    logic                  clk;
    logic                  reset;
    logic                  cfg_write;
    biquad_pkg::cfg_addr_t cfg_addr;
    biquad_pkg::cfg_data_t cfg_data;
    logic                  sample_valid;
    biquad_pkg::sample_t   sample_in;
    logic                  out_valid;
    biquad_pkg::sample_t   sample_out;

    // Model coefficients and histories, per section
    int m_b0 [2] = '{0, 0};
    int m_b1 [2] = '{0, 0};
    int m_b2 [2] = '{0, 0};
    int m_a1 [2] = '{0, 0};
    int m_a2 [2] = '{0, 0};
    int m_byp [2] = '{0, 0};
    int hx1 [2] = '{0, 0};
    int hx2 [2] = '{0, 0};
    int hy1 [2] = '{0, 0};
    int hy2 [2] = '{0, 0};

    // Expected outputs in flight, with send cycle and test name
    int    exp_q [$];
    int    stamp_q [$];
    string name_q [$];

    logic [31:0] lfsr = 32'h07ad_be71;
    string       test_name = "reset";
    int          error_count = 0;
    int          cycle_count = 0;
    int          sat_count = 0;

    tb_clock_gen #(.PERIOD_NS(100.0)) u_clk (.clk(clk));

    biquad_cascade_top uut (
        .clk          (clk),
        .reset        (reset),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .sample_valid (sample_valid),
        .sample_in    (sample_in),
        .out_valid    (out_valid),
        .sample_out   (sample_out)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_signed(input int n, output int val);
        logic [31:0] v;
        rand_bits(n, v);
        val = int'(v);
        if (v[n-1]) val = val - (1 << n);
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (expected !== actual) begin
            error_count++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Direct form I step: sum, floor shift by 14, clamp, then shift histories
    function automatic int model_section(input int s, input int x);
        longint acc;
        longint y;
        if (m_byp[s] != 0) begin
            y = x;
        end else begin
            acc = longint'(m_b0[s]) * x + longint'(m_b1[s]) * hx1[s]
                + longint'(m_b2[s]) * hx2[s] - longint'(m_a1[s]) * hy1[s]
                - longint'(m_a2[s]) * hy2[s];
            y = acc >>> 14;
            if (y > Y_MAX || y < Y_MIN) sat_count++;
            if (y > Y_MAX) y = Y_MAX;
            if (y < Y_MIN) y = Y_MIN;
        end
        hx2[s] = hx1[s];
        hx1[s] = x;
        hy2[s] = hy1[s];
        hy1[s] = int'(y);
        return int'(y);
    endfunction

    // Strobes drop 10 ns after each rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
        cfg_write = 1'b0;
        sample_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic random_gap(input int bits);
        logic [31:0] v;
        rand_bits(bits, v);
        idle(int'(v));
    endtask

    task automatic write_reg(input int s, input int idx, input int data);
        next_cycle();
        cfg_write = 1'b1;
        cfg_addr = biquad_pkg::cfg_addr_t'(s * 8 + idx);
        cfg_data = biquad_pkg::cfg_data_t'(data);
        case (idx)
            IDX_B0: m_b0[s] = data;
            IDX_B1: m_b1[s] = data;
            IDX_B2: m_b2[s] = data;
            IDX_A1: m_a1[s] = data;
            IDX_A2: m_a2[s] = data;
            default: m_byp[s] = data & 1;
        endcase
    endtask

    task automatic write_config(input int s, input int b0, input int b1, input int b2,
                                input int a1, input int a2);
        write_reg(s, IDX_B0, b0);
        write_reg(s, IDX_B1, b1);
        write_reg(s, IDX_B2, b2);
        write_reg(s, IDX_A1, a1);
        write_reg(s, IDX_A2, a2);
    endtask

    // Stability triangle: |a2| < 1 and |a1| < 1 + a2, kept well inside
    task automatic random_config(input int s);
        int b0;
        int b1;
        int b2;
        int a2;
        int lim;
        logic [31:0] v;
        rand_signed(15, b0);
        rand_signed(15, b1);
        rand_signed(15, b2);
        rand_signed(14, a2);
        lim = (16384 + a2) / 2;
        rand_bits(16, v);
        write_config(s, b0, b1, b2, int'(v % (2 * lim + 1)) - lim, a2);
    endtask

    // Model both sections at drive time, outputs expected 2 cycles later
    task automatic send_sample(input int x);
        int y0;
        next_cycle();
        sample_valid = 1'b1;
        sample_in = biquad_pkg::sample_t'(x);
        y0 = model_section(0, x);
        exp_q.push_back(model_section(1, y0));
        stamp_q.push_back(cycle_count);
        name_q.push_back(test_name);
    endtask

    always @(posedge clk) cycle_count++;

    // Outputs settle after the rising edge, so sample them on the falling one
    always @(negedge clk) begin
        string nm;
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("out_valid rose with no sample in flight during %s", test_name);
            end else begin
                nm = name_q.pop_front();
                check_value(nm, exp_q.pop_front(), longint'(sample_out));
                check_value({nm, " latency"}, 2, cycle_count - stamp_q.pop_front());
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, outputs stopped arriving", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int x;
        logic [31:0] v;
        reset = 1'b1;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        sample_valid = 1'b0;
        sample_in = '0;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        // Quiet outputs after reset
        for (int i = 0; i < 10; i++) begin
            next_cycle();
            check_value("reset out_valid", 0, longint'(out_valid));
            check_value("reset sample_out", 0, longint'(sample_out));
        end

        // Unity gain, first half back to back
        test_name = "unity";
        write_config(0, 16384, 0, 0, 0, 0);
        write_config(1, 16384, 0, 0, 0, 0);
        for (int i = 0; i < N_UNITY; i++) begin
            rand_signed(24, x);
            send_sample(x);
            if (i >= N_UNITY / 2) random_gap(1);
        end

        test_name = "random";
        random_config(0);
        random_config(1);
        for (int i = 0; i < N_RAND; i++) begin
            rand_signed(20, x);
            send_sample(x);
            random_gap(2);
        end

        // Gain near 2.0 in section 0 with full-scale input
        test_name = "saturation";
        sat_count = 0;
        write_config(0, 32767, 0, 0, 0, 0);
        write_config(1, 16384, 0, 0, 0, 0);
        for (int i = 0; i < N_SAT; i++) begin
            rand_signed(24, x);
            send_sample(x);
            random_gap(1);
        end
        if (sat_count == 0) begin
            error_count++;
            $display("Saturation test produced no clamped outputs");
        end

        // Modes 1, 2, 3: section 0, section 1, both bypassed
        test_name = "bypass";
        for (int mode = 1; mode <= 3; mode++) begin
            random_config(0);
            random_config(1);
            write_reg(0, IDX_BYPASS, mode & 1);
            write_reg(1, IDX_BYPASS, (mode >> 1) & 1);
            for (int i = 0; i < N_BYP / 3; i++) begin
                rand_signed(20, x);
                send_sample(x);
                random_gap(1);
            end
        end
        write_reg(0, IDX_BYPASS, 0);
        write_reg(1, IDX_BYPASS, 0);

        // Rewrites land right behind samples still in the pipeline
        test_name = "coef change";
        random_config(0);
        random_config(1);
        for (int i = 0; i < N_CHG; i++) begin
            rand_signed(20, x);
            send_sample(x);
            random_gap(1);
            if (i % 15 == 14) begin
                rand_bits(1, v);
                random_config(int'(v[0]));
            end
        end

        while (exp_q.size() != 0) next_cycle();
        idle(4);

        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the biquad cascade testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_biquad_cascade
OBJ_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module "$TOP" --Mdir "$OBJ_DIR" -f sources.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$OBJ_DIR/V$TOP" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

/* sources.f */
src/biquad_pkg.sv
src/biquad_coef_if.sv
src/biquad_coef_regs.sv
src/biquad_section.sv
src/biquad_cascade_top.sv
dv/tb_clock_gen.sv
dv/tb_biquad_cascade.sv

/* src/biquad_cascade_top.sv */
`timescale 1ns/10ps

module biquad_cascade_top #(
    parameter int NUM_SECTIONS = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_write,
    input  biquad_pkg::cfg_addr_t cfg_addr,
    input  biquad_pkg::cfg_data_t cfg_data,
    input  logic                  sample_valid,
    input  biquad_pkg::sample_t   sample_in,
    output logic                  out_valid,
    output biquad_pkg::sample_t   sample_out
);

    // Strobe and sample between sections, entry k feeds section k
    logic                valid_chain  [NUM_SECTIONS+1];
    biquad_pkg::sample_t sample_chain [NUM_SECTIONS+1];

    // One coefficient bundle per section
    biquad_coef_if coef_bus [NUM_SECTIONS] ();

    // Configuration registers
    biquad_coef_regs #(
        .NUM_SECTIONS (NUM_SECTIONS)
    ) u_regs (
        .clk       (clk),
        .reset     (reset),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .coef      (coef_bus)
    );

    // Head of the chain
    assign valid_chain[0]  = sample_valid;
    assign sample_chain[0] = sample_in;

    // One cycle of latency per section
    for (genvar k = 0; k < NUM_SECTIONS; k++) begin : g_stage
        biquad_section u_section (
            .clk        (clk),
            .reset      (reset),
            .coef       (coef_bus[k]),
            .valid_in   (valid_chain[k]),
            .sample_in  (sample_chain[k]),
            .valid_out  (valid_chain[k+1]),
            .sample_out (sample_chain[k+1])
        );
    end

    // Tail of the chain
    assign out_valid  = valid_chain[NUM_SECTIONS];
    assign sample_out = sample_chain[NUM_SECTIONS];

endmodule

/* src/biquad_coef_if.sv */
`timescale 1ns/10ps

// Coefficients and bypass for one biquad section
interface biquad_coef_if;

    // Feed-forward taps
    biquad_pkg::coef_t b0;
    biquad_pkg::coef_t b1;
    biquad_pkg::coef_t b2;

    // Feedback taps, subtracted in the section
    biquad_pkg::coef_t a1;
    biquad_pkg::coef_t a2;

    // Pass the input straight through
    logic bypass;

    // Register block side
    modport regs (output b0, b1, b2, a1, a2, bypass);

    // Filter section side
    modport section (input b0, b1, b2, a1, a2, bypass);

endinterface

/* src/biquad_coef_regs.sv */
`timescale 1ns/10ps

module biquad_coef_regs #(
    parameter int NUM_SECTIONS = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_write,
    input  biquad_pkg::cfg_addr_t cfg_addr,
    input  biquad_pkg::cfg_data_t cfg_data,
    biquad_coef_if.regs           coef [NUM_SECTIONS]
);

    // Width of the section number field in the address
    localparam int SECT_BITS = $bits(biquad_pkg::cfg_addr_t) - biquad_pkg::REG_IDX_BITS;

    // Address split into section number and register index
    logic [SECT_BITS-1:0]  sect;
    biquad_pkg::reg_idx_t  idx;

    assign sect = cfg_addr[$bits(biquad_pkg::cfg_addr_t)-1:biquad_pkg::REG_IDX_BITS];
    assign idx  = cfg_addr[biquad_pkg::REG_IDX_BITS-1:0];

    for (genvar s = 0; s < NUM_SECTIONS; s++) begin : g_sect

        // This section's registers
        biquad_pkg::coef_t b0_q;
        biquad_pkg::coef_t b1_q;
        biquad_pkg::coef_t b2_q;
        biquad_pkg::coef_t a1_q;
        biquad_pkg::coef_t a2_q;
        logic              bypass_q;

        // Write aimed at this section
        logic sel;
        assign sel = cfg_write && (sect == SECT_BITS'(s));

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                b0_q     <= '0;
                b1_q     <= '0;
                b2_q     <= '0;
                a1_q     <= '0;
                a2_q     <= '0;
                bypass_q <= 1'b0;
            end else if (sel) begin
                // Index 6 and 7 fall through and change nothing
                case (idx)
                    biquad_pkg::REG_B0:     b0_q     <= biquad_pkg::coef_t'(cfg_data);
                    biquad_pkg::REG_B1:     b1_q     <= biquad_pkg::coef_t'(cfg_data);
                    biquad_pkg::REG_B2:     b2_q     <= biquad_pkg::coef_t'(cfg_data);
                    biquad_pkg::REG_A1:     a1_q     <= biquad_pkg::coef_t'(cfg_data);
                    biquad_pkg::REG_A2:     a2_q     <= biquad_pkg::coef_t'(cfg_data);
                    biquad_pkg::REG_BYPASS: bypass_q <= cfg_data[0];
                    default: ;
                endcase
            end
        end

        // Visible to the section right after the write edge
        assign coef[s].b0     = b0_q;
        assign coef[s].b1     = b1_q;
        assign coef[s].b2     = b2_q;
        assign coef[s].a1     = a1_q;
        assign coef[s].a2     = a2_q;
        assign coef[s].bypass = bypass_q;
    end

    // Writes outside the map are dropped, flag them
    a_cfg_addr_in_map : assert property (
        @(posedge clk) disable iff (reset)
        cfg_write |-> ((int'(sect) < NUM_SECTIONS) && (idx <= biquad_pkg::REG_BYPASS))
    ) else $warning("config write to unmapped address %0h ignored", cfg_addr);

endmodule

/* src/biquad_pkg.sv */
package biquad_pkg;

    // Signed audio sample
    typedef logic signed [23:0] sample_t;

    // Signed Q2.14 coefficient, 16384 is unity
    typedef logic signed [15:0] coef_t;

    // Five 40-bit products summed without wrapping
    typedef logic signed [42:0] acc_t;

    // Configuration bus
    typedef logic [7:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // Register index inside one section's block of eight
    typedef logic [2:0] reg_idx_t;

    // Register map, per section
    localparam reg_idx_t REG_B0     = 3'd0;
    localparam reg_idx_t REG_B1     = 3'd1;
    localparam reg_idx_t REG_B2     = 3'd2;
    localparam reg_idx_t REG_A1     = 3'd3;
    localparam reg_idx_t REG_A2     = 3'd4;
    localparam reg_idx_t REG_BYPASS = 3'd5;

    // Address bits above the index select the section
    localparam int REG_IDX_BITS = $bits(reg_idx_t);

    // Fractional coefficient bits, sets the rescale shift
    localparam int COEF_FRAC_BITS = 14;

    // Product of one sample and one coefficient
    localparam int PROD_BITS = $bits(sample_t) + $bits(coef_t);

    // Saturation limits
    localparam sample_t SAMPLE_MAX = 24'sh7f_ffff;
    localparam sample_t SAMPLE_MIN = 24'sh80_0000;

endpackage

/* src/biquad_section.sv */
`timescale 1ns/10ps

module biquad_section (
    input  logic                clk,
    input  logic                reset,
    biquad_coef_if.section      coef,
    input  logic                valid_in,
    input  biquad_pkg::sample_t sample_in,
    output logic                valid_out,
    output biquad_pkg::sample_t sample_out
);

    // Full-precision product of a sample and a coefficient
    typedef logic signed [biquad_pkg::PROD_BITS-1:0] prod_t;

    // Input history x[n-1], x[n-2]
    biquad_pkg::sample_t x1;
    biquad_pkg::sample_t x2;

    // Output history y[n-1], y[n-2]
    biquad_pkg::sample_t y1;
    biquad_pkg::sample_t y2;

    // Tap products
    prod_t p_b0;
    prod_t p_b1;
    prod_t p_b2;
    prod_t p_a1;
    prod_t p_a2;

    // Sum, rescaled sum, clamped and selected result
    biquad_pkg::acc_t    acc;
    biquad_pkg::acc_t    acc_scaled;
    biquad_pkg::sample_t y_sat;
    biquad_pkg::sample_t y_next;

    // Operands sign-extend to the product width
    assign p_b0 = coef.b0 * sample_in;
    assign p_b1 = coef.b1 * x1;
    assign p_b2 = coef.b2 * x2;
    assign p_a1 = coef.a1 * y1;
    assign p_a2 = coef.a2 * y2;

    // Three extra bits keep the five-term sum from wrapping
    assign acc = biquad_pkg::acc_t'(p_b0)
               + biquad_pkg::acc_t'(p_b1)
               + biquad_pkg::acc_t'(p_b2)
               - biquad_pkg::acc_t'(p_a1)
               - biquad_pkg::acc_t'(p_a2);

    // Back to sample scale with floor rounding
    assign acc_scaled = acc >>> biquad_pkg::COEF_FRAC_BITS;

    // Clamp into the sample range
    always_comb begin
        if (acc_scaled > biquad_pkg::acc_t'(biquad_pkg::SAMPLE_MAX)) begin
            y_sat = biquad_pkg::SAMPLE_MAX;
        end else if (acc_scaled < biquad_pkg::acc_t'(biquad_pkg::SAMPLE_MIN)) begin
            y_sat = biquad_pkg::SAMPLE_MIN;
        end else begin
            y_sat = biquad_pkg::sample_t'(acc_scaled);
        end
    end

    // Bypass forwards x[n] to the output and into the y history
    assign y_next = coef.bypass ? sample_in : y_sat;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_out  <= 1'b0;
            sample_out <= '0;
            x1         <= '0;
            x2         <= '0;
            y1         <= '0;
            y2         <= '0;
        end else begin
            // One-cycle strobe per accepted sample
            valid_out <= valid_in;
            if (valid_in) begin
                sample_out <= y_next;
                // Shift histories only on a sample
                x2 <= x1;
                x1 <= sample_in;
                y2 <= y1;
                y1 <= y_next;
            end
        end
    end

    // Output strobe only ever follows an input strobe by one cycle
    a_valid_latency : assert property (
        @(posedge clk) disable iff (reset)
        valid_out |-> $past(valid_in)
    ) else $error("valid_out without valid_in one cycle earlier");

    // Clamped output keeps the sign of the wide sum, so it never wraps
    a_out_no_wrap : assert property (
        @(posedge clk) disable iff (reset)
        (valid_in && !coef.bypass) |=> ((sample_out < 0) == ($past(acc_scaled) < 0))
    ) else $error("sample_out %0d wrapped instead of saturating", sample_out);

endmodule
